// ==== cpuPkg.sv ====
package cpuPkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0] regAddr_t;
    typedef logic [5:0] dataAddr_t;    // word index into the data RAM

    localparam int DATA_WORDS = 64;

    // primary opcodes
    localparam logic [5:0] OPC_SPECIAL = 6'h00;
    localparam logic [5:0] OPC_BEQ = 6'h04;
    localparam logic [5:0] OPC_BNE = 6'h05;
    localparam logic [5:0] OPC_ADDIU = 6'h09;
    localparam logic [5:0] OPC_LW = 6'h23;
    localparam logic [5:0] OPC_SW = 6'h2b;

    // function field of OPC_SPECIAL
    localparam logic [5:0] FN_ADDU = 6'h21;
    localparam logic [5:0] FN_SUBU = 6'h23;
    localparam logic [5:0] FN_AND = 6'h24;
    localparam logic [5:0] FN_OR = 6'h25;

    typedef enum logic [3:0] {
        OP_NOP,    // also anything not implemented
        OP_ADDU,
        OP_SUBU,
        OP_AND,
        OP_OR,
        OP_ADDIU,
        OP_LW,
        OP_SW,
        OP_BEQ,
        OP_BNE
    } decodedOp_t;

    typedef enum logic [1:0] {
        NOFORWARD,
        ALUOUTM,
        RESULTW
    } forward_t;

endpackage

// ==== pipeIntf.sv ====
`timescale 1ns/1ns

interface stageIntf import cpuPkg::*; ();
    logic valid;
    decodedOp_t op;
    regAddr_t rs;
    regAddr_t rt;
    regAddr_t writeReg;
    logic regWrite;
    logic memToReg;
    word_t srcA;
    word_t srcB;    // store data once past execute
    word_t imm;
    word_t aluOut;
    word_t result;

    modport src (output valid, op, rs, rt, writeReg, regWrite, memToReg,
                 srcA, srcB, imm, aluOut, result);
    modport dst (input valid, op, rs, rt, writeReg, regWrite, memToReg,
                 srcA, srcB, imm, aluOut, result);
    modport mon (input valid, op, rs, rt, writeReg, regWrite, memToReg,
                 srcA, srcB, imm, aluOut, result);
endinterface

interface hazardIntf import cpuPkg::*; ();
    logic stallF;
    logic stallD;
    logic flushE;
    forward_t forwardAD;
    forward_t forwardBD;
    forward_t forwardAE;
    forward_t forwardBE;
    logic instrOk;

    modport hazard (output stallF, stallD, flushE, forwardAD, forwardBD, forwardAE, forwardBE,
                    input instrOk);
    modport stage (input stallF, stallD, flushE, forwardAD, forwardBD, forwardAE, forwardBE,
                   output instrOk);
endinterface

// ==== fetchStage.sv ====
`timescale 1ns/1ns

module fetchStage import cpuPkg::*; (
    input logic clk,
    input logic arstN,
    hazardIntf.stage hz,
    output word_t instrAddr,
    input word_t instrData,
    input logic branchTaken,
    input word_t branchTarget,
    output word_t instrD,
    output word_t pcPlus4D
);
    word_t pc;
    word_t pcPlus4;
    word_t pcNext;

    assign instrAddr = pc;
    assign pcPlus4 = pc + 32'd4;
    // the branch sits in decode while its delay slot is fetched here
    assign pcNext = branchTaken ? branchTarget : pcPlus4;

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            pc <= '0;
            instrD <= '0;
        end else begin
            if (!hz.stallF) begin
                pc <= pcNext;
            end
            if (!hz.stallD) begin
                instrD <= instrData;    // decode is held while nothing arrives
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!hz.stallD) begin
            pcPlus4D <= pcPlus4;
        end
    end

    pcHeld: assert property (@(posedge clk) disable iff (!arstN) hz.stallF |=> $stable(pc));

endmodule

// ==== decodeStage.sv ====
`timescale 1ns/1ns

module decodeStage import cpuPkg::*; (
    input logic clk,
    input logic arstN,
    input word_t instrD,
    input word_t pcPlus4D,
    hazardIntf.stage hz,
    stageIntf.src toE,
    stageIntf.mon fromM,
    stageIntf.mon fromW,
    output regAddr_t rsD,
    output regAddr_t rtD,
    output logic isBranchD,
    output logic branchTaken,
    output word_t branchTarget
);
    logic [5:0] opcode;
    logic [5:0] funct;
    regAddr_t rdD;
    decodedOp_t opD;
    word_t immD;
    logic regWriteD;
    logic memToRegD;
    regAddr_t writeRegD;
    word_t regs [32];
    logic wrW;
    word_t regA;
    word_t regB;
    word_t brA;
    word_t brB;

    assign opcode = instrD[31:26];
    assign rsD = instrD[25:21];
    assign rtD = instrD[20:16];
    assign rdD = instrD[15:11];
    assign funct = instrD[5:0];
    assign immD = {{16{instrD[15]}}, instrD[15:0]};

    always_comb begin
        case (opcode)
            OPC_SPECIAL: begin
                case (funct)
                    FN_ADDU: opD = OP_ADDU;
                    FN_SUBU: opD = OP_SUBU;
                    FN_AND: opD = OP_AND;
                    FN_OR: opD = OP_OR;
                    default: opD = OP_NOP;    // word 0 lands here
                endcase
            end
            OPC_ADDIU: opD = OP_ADDIU;
            OPC_LW: opD = OP_LW;
            OPC_SW: opD = OP_SW;
            OPC_BEQ: opD = OP_BEQ;
            OPC_BNE: opD = OP_BNE;
            default: opD = OP_NOP;
        endcase
    end

    assign regWriteD = opD inside {OP_ADDU, OP_SUBU, OP_AND, OP_OR, OP_ADDIU, OP_LW};
    assign memToRegD = (opD == OP_LW);
    assign writeRegD = (opD inside {OP_ADDIU, OP_LW}) ? rtD : rdD;
    assign isBranchD = (opD == OP_BEQ) || (opD == OP_BNE);

    // register file, written from the writeback record
    assign wrW = fromW.valid && fromW.regWrite && (fromW.writeReg != '0);

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wrW) begin
            regs[fromW.writeReg] <= fromW.result;
        end
    end

    // write-first
    assign regA = (wrW && fromW.writeReg == rsD) ? fromW.result : regs[rsD];
    assign regB = (wrW && fromW.writeReg == rtD) ? fromW.result : regs[rtD];

    always_comb begin
        case (hz.forwardAD)
            ALUOUTM: brA = fromM.aluOut;
            default: brA = regA;
        endcase
        case (hz.forwardBD)
            ALUOUTM: brB = fromM.aluOut;
            default: brB = regB;
        endcase
    end

    assign branchTaken = ((opD == OP_BEQ) && (brA == brB)) || ((opD == OP_BNE) && (brA != brB));
    assign branchTarget = pcPlus4D + {immD[29:0], 2'b00};    // relative to the delay slot

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            toE.valid <= 1'b0;
            toE.op <= OP_NOP;
            toE.regWrite <= 1'b0;
            toE.memToReg <= 1'b0;
        end else if (hz.flushE) begin
            toE.valid <= 1'b0;    // bubble
            toE.op <= OP_NOP;
            toE.regWrite <= 1'b0;
            toE.memToReg <= 1'b0;
        end else begin
            toE.valid <= 1'b1;
            toE.op <= opD;
            toE.regWrite <= regWriteD;
            toE.memToReg <= memToRegD;
        end
    end

    always_ff @(posedge clk) begin
        toE.rs <= rsD;
        toE.rt <= rtD;
        toE.writeReg <= writeRegD;
        toE.srcA <= regA;
        toE.srcB <= regB;
        toE.imm <= immD;
    end

    assign toE.aluOut = '0;    // filled in execute
    assign toE.result = '0;

    zeroReg: assert property (@(posedge clk) disable iff (!arstN) regs[0] == '0);

endmodule

// ==== executeStage.sv ====
`timescale 1ns/1ns

module executeStage import cpuPkg::*; (
    input logic clk,
    input logic arstN,
    stageIntf.dst fromD,
    hazardIntf.stage hz,
    stageIntf.src toM,
    stageIntf.mon fromM,
    stageIntf.mon fromW
);
    word_t srcAE;
    word_t srcBE;
    word_t aluB;
    word_t aluOutE;

    always_comb begin
        case (hz.forwardAE)
            ALUOUTM: srcAE = fromM.aluOut;
            RESULTW: srcAE = fromW.result;
            default: srcAE = fromD.srcA;
        endcase
        case (hz.forwardBE)
            ALUOUTM: srcBE = fromM.aluOut;
            RESULTW: srcBE = fromW.result;
            default: srcBE = fromD.srcB;
        endcase
    end

    assign aluB = (fromD.op inside {OP_ADDIU, OP_LW, OP_SW}) ? fromD.imm : srcBE;

    always_comb begin
        case (fromD.op)
            OP_SUBU: aluOutE = srcAE - aluB;
            OP_AND: aluOutE = srcAE & aluB;
            OP_OR: aluOutE = srcAE | aluB;
            default: aluOutE = srcAE + aluB;    // addu, addiu and addresses
        endcase
    end

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            toM.valid <= 1'b0;
            toM.op <= OP_NOP;
            toM.regWrite <= 1'b0;
            toM.memToReg <= 1'b0;
        end else begin
            toM.valid <= fromD.valid;
            toM.op <= fromD.op;
            toM.regWrite <= fromD.regWrite;
            toM.memToReg <= fromD.memToReg;
        end
    end

    always_ff @(posedge clk) begin
        toM.rs <= fromD.rs;
        toM.rt <= fromD.rt;
        toM.writeReg <= fromD.writeReg;
        toM.srcA <= srcAE;
        toM.srcB <= srcBE;    // forwarded store data
        toM.imm <= fromD.imm;
        toM.aluOut <= aluOutE;
    end

    assign toM.result = '0;

endmodule

// ==== memoryStage.sv ====
`timescale 1ns/1ns

module memoryStage import cpuPkg::*; (
    input logic clk,
    input logic arstN,
    stageIntf.dst fromE,
    stageIntf.src toW,
    output logic wbValid,
    output regAddr_t wbReg,
    output word_t wbData
);
    word_t ram [DATA_WORDS];
    dataAddr_t wordIdx;
    word_t readData;
    logic storeM;

    assign wordIdx = fromE.aluOut[7:2];
    assign readData = ram[wordIdx];    // asynchronous read
    assign storeM = fromE.valid && (fromE.op == OP_SW);

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            for (int i = 0; i < DATA_WORDS; i++) begin
                ram[i] <= '0;
            end
        end else if (storeM) begin
            ram[wordIdx] <= fromE.srcB;
        end
    end

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            toW.valid <= 1'b0;
            toW.op <= OP_NOP;
            toW.regWrite <= 1'b0;
            toW.memToReg <= 1'b0;
        end else begin
            toW.valid <= fromE.valid;
            toW.op <= fromE.op;
            toW.regWrite <= fromE.regWrite;
            toW.memToReg <= fromE.memToReg;
        end
    end

    always_ff @(posedge clk) begin
        toW.rs <= fromE.rs;
        toW.rt <= fromE.rt;
        toW.writeReg <= fromE.writeReg;
        toW.srcA <= fromE.srcA;
        toW.srcB <= fromE.srcB;
        toW.imm <= fromE.imm;
        toW.aluOut <= fromE.aluOut;
        toW.result <= fromE.memToReg ? readData : fromE.aluOut;
    end

    assign wbValid = toW.valid && toW.regWrite && (toW.writeReg != '0);
    assign wbReg = toW.writeReg;
    assign wbData = toW.result;

    storeAddrKnown: assert property (@(posedge clk) disable iff (!arstN)
        storeM |-> !$isunknown(fromE.aluOut[7:2]));

endmodule

// ==== hazard.sv ====
`timescale 1ns/1ns

module hazard import cpuPkg::*; (
    hazardIntf.hazard hz,
    stageIntf.mon recE,
    stageIntf.mon recM,
    stageIntf.mon recW,
    input regAddr_t rsD,
    input regAddr_t rtD,
    input logic isBranchD
);
    logic writesE;
    logic writesM;
    logic writesW;
    logic matchE;
    logic matchM;
    logic lwStall;
    logic branchStall;
    logic stall;

    // register 0 never counts as a destination
    assign writesE = recE.valid && recE.regWrite && (recE.writeReg != '0);
    assign writesM = recM.valid && recM.regWrite && (recM.writeReg != '0);
    assign writesW = recW.valid && recW.regWrite && (recW.writeReg != '0);

    assign matchE = writesE && ((recE.writeReg == rsD) || (recE.writeReg == rtD));
    assign matchM = writesM && ((recM.writeReg == rsD) || (recM.writeReg == rtD));

    assign lwStall = matchE && recE.memToReg;
    // no execute source for branch operands, so the branch waits
    assign branchStall = isBranchD && (matchE || (matchM && recM.memToReg));
    assign stall = lwStall || branchStall || !hz.instrOk;

    assign hz.stallF = stall;
    assign hz.stallD = stall;
    assign hz.flushE = stall;

    always_comb begin
        hz.forwardAD = NOFORWARD;
        hz.forwardBD = NOFORWARD;
        hz.forwardAE = NOFORWARD;
        hz.forwardBE = NOFORWARD;
        if (writesM && recM.writeReg == rsD) begin
            hz.forwardAD = ALUOUTM;
        end
        if (writesM && recM.writeReg == rtD) begin
            hz.forwardBD = ALUOUTM;
        end
        if (writesM && recM.writeReg == recE.rs) begin
            hz.forwardAE = ALUOUTM;
        end else if (writesW && recW.writeReg == recE.rs) begin
            hz.forwardAE = RESULTW;
        end
        if (writesM && recM.writeReg == recE.rt) begin
            hz.forwardBE = ALUOUTM;
        end else if (writesW && recW.writeReg == recE.rt) begin
            hz.forwardBE = RESULTW;
        end
    end

endmodule

// ==== cpuTop.sv ====
`timescale 1ns/1ns

module cpuTop import cpuPkg::*; (
    input logic clk,
    input logic arstN,
    output word_t instrAddr,
    input word_t instrData,
    input logic instrOk,
    output logic wbValid,
    output regAddr_t wbReg,
    output word_t wbData
);
    hazardIntf hzIf ();
    stageIntf dToE ();
    stageIntf eToM ();
    stageIntf mToW ();

    word_t instrD;
    word_t pcPlus4D;
    word_t branchTarget;
    logic branchTaken;
    logic isBranchD;
    regAddr_t rsD;
    regAddr_t rtD;

    assign hzIf.instrOk = instrOk;

    fetchStage uFetch (
        .clk(clk),
        .arstN(arstN),
        .hz(hzIf),
        .instrAddr(instrAddr),
        .instrData(instrData),
        .branchTaken(branchTaken),
        .branchTarget(branchTarget),
        .instrD(instrD),
        .pcPlus4D(pcPlus4D)
    );

    decodeStage uDecode (
        .clk(clk),
        .arstN(arstN),
        .instrD(instrD),
        .pcPlus4D(pcPlus4D),
        .hz(hzIf),
        .toE(dToE),
        .fromM(eToM),
        .fromW(mToW),
        .rsD(rsD),
        .rtD(rtD),
        .isBranchD(isBranchD),
        .branchTaken(branchTaken),
        .branchTarget(branchTarget)
    );

    executeStage uExecute (
        .clk(clk),
        .arstN(arstN),
        .fromD(dToE),
        .hz(hzIf),
        .toM(eToM),
        .fromM(eToM),
        .fromW(mToW)
    );

    memoryStage uMemory (
        .clk(clk),
        .arstN(arstN),
        .fromE(eToM),
        .toW(mToW),
        .wbValid(wbValid),
        .wbReg(wbReg),
        .wbData(wbData)
    );

    hazard uHazard (
        .hz(hzIf),
        .recE(dToE),
        .recM(eToM),
        .recW(mToW),
        .rsD(rsD),
        .rtD(rtD),
        .isBranchD(isBranchD)
    );

endmodule

// ==== tbCpu.sv ====
`timescale 1ns/1ns

module tbCpu import cpuPkg::*; ();
    localparam int NUM_TESTS = 5;
    localparam int PROG_WORDS = 60;
    localparam int END_ADDR = (PROG_WORDS + 8) * 4;    // whole program is past decode by then
    localparam int DRAIN_CYCLES = 6;
    localparam int TEST_CYCLES = 64 * 6;
    localparam int WATCHDOG_NS = NUM_TESTS * 64 * 8 * 10;

    logic clk = 1'b0;
    logic arstN;
    word_t instrAddr;
    word_t instrData;
    logic instrOk;
    logic wbValid;
    regAddr_t wbReg;
    word_t wbData;

    integer seed = 32'hdd41b861;
    int errors = 0;
    int failedTests = 0;
    word_t prog [PROG_WORDS];
    regAddr_t expReg [$];
    word_t expData [$];
    regAddr_t gotReg [$];
    word_t gotData [$];

    cpuTop DUT (
        .clk(clk),
        .arstN(arstN),
        .instrAddr(instrAddr),
        .instrData(instrData),
        .instrOk(instrOk),
        .wbValid(wbValid),
        .wbReg(wbReg),
        .wbData(wbData)
    );

    initial begin
        forever #5 clk = ~clk;
    end

    task automatic compare(input string name, input word_t expected, input word_t actual);
        if (expected !== actual) begin
            $display("FAILED %s: expected %h, actual %h", name, expected, actual);
            errors++;
        end
    endtask

    task automatic buildProgram();
        word_t r;
        word_t v;
        logic [5:0] fn;
        logic [5:0] wordIdx;
        logic lastBranch;
        lastBranch = 1'b0;
        for (int i = 0; i < PROG_WORDS; i++) begin
            r = $random(seed);
            v = $random(seed);
            wordIdx = v[20] ? v[26:21] : {3'b000, v[23:21]};    // mostly a few shared words
            if (r[15:14] == 2'b11 && !lastBranch) begin
                prog[i] = {r[12] ? OPC_BNE : OPC_BEQ, 2'b00, r[2:0], 2'b00, r[5:3],
                           13'd0, {1'b0, v[1:0]} + 3'd1};
                lastBranch = 1'b1;
            end else begin
                lastBranch = 1'b0;    // nothing below may sit in a delay slot and branch
                case (r[15:12])
                    4'd0: prog[i] = '0;
                    4'd6, 4'd7: prog[i] = {OPC_ADDIU, 2'b00, r[2:0], 2'b00, r[5:3], v[15:0]};
                    4'd8, 4'd9: prog[i] = {OPC_LW, 5'd0, 2'b00, r[5:3], 8'd0, wordIdx, 2'b00};
                    4'd10, 4'd11: prog[i] = {OPC_SW, 5'd0, 2'b00, r[5:3], 8'd0, wordIdx, 2'b00};
                    default: begin
                        case (r[15:12])
                            4'd3: fn = FN_SUBU;
                            4'd4: fn = FN_AND;
                            4'd5: fn = FN_OR;
                            default: fn = FN_ADDU;
                        endcase
                        prog[i] = {OPC_SPECIAL, 2'b00, r[2:0], 2'b00, r[5:3], 2'b00, r[8:6],
                                   5'd0, fn};
                    end
                endcase
            end
        end
    endtask

    // instruction-set model, one delay slot after every branch
    task automatic modelProgram();
        word_t regs [32];
        word_t dmem [DATA_WORDS];
        word_t instr;
        word_t a;
        word_t b;
        word_t imm;
        word_t addr;
        word_t val;
        regAddr_t dest;
        logic writes;
        int pcIdx;
        int npcIdx;
        int nextNpc;
        for (int i = 0; i < 32; i++) begin
            regs[i] = '0;
        end
        for (int i = 0; i < DATA_WORDS; i++) begin
            dmem[i] = '0;
        end
        expReg.delete();
        expData.delete();
        pcIdx = 0;
        npcIdx = 1;
        while (pcIdx < PROG_WORDS) begin
            instr = prog[pcIdx];
            a = regs[instr[25:21]];
            b = regs[instr[20:16]];
            imm = {{16{instr[15]}}, instr[15:0]};
            addr = a + imm;
            nextNpc = npcIdx + 1;
            writes = 1'b0;
            dest = instr[20:16];
            val = '0;
            case (instr[31:26])
                OPC_SPECIAL: begin
                    dest = instr[15:11];
                    writes = 1'b1;
                    case (instr[5:0])
                        FN_ADDU: val = a + b;
                        FN_SUBU: val = a - b;
                        FN_AND: val = a & b;
                        FN_OR: val = a | b;
                        default: writes = 1'b0;    // word 0
                    endcase
                end
                OPC_ADDIU: begin
                    writes = 1'b1;
                    val = addr;
                end
                OPC_LW: begin
                    writes = 1'b1;
                    val = dmem[addr[7:2]];
                end
                OPC_SW: dmem[addr[7:2]] = b;
                OPC_BEQ: if (a == b) nextNpc = pcIdx + 1 + int'(imm);
                OPC_BNE: if (a != b) nextNpc = pcIdx + 1 + int'(imm);
                default: ;
            endcase
            if (writes && dest != '0) begin
                regs[dest] = val;
                expReg.push_back(dest);
                expData.push_back(val);
            end
            pcIdx = npcIdx;
            npcIdx = nextNpc;
        end
    endtask

    task automatic answerFetch();
        word_t r;
        r = $random(seed);
        instrOk = (r[1:0] != 2'b00);    // low about one cycle in four
        if (instrAddr < PROG_WORDS * 4) begin
            instrData = prog[instrAddr[7:2]];
        end else begin
            instrData = '0;
        end
    endtask

    task automatic runTest(input int testNum);
        int cycles;
        int drainLeft;
        int errorsBefore;
        int errorsList;
        int n;
        errorsBefore = errors;
        buildProgram();
        modelProgram();
        gotReg.delete();
        gotData.delete();
        arstN = 1'b0;
        instrOk = 1'b0;
        instrData = '0;
        repeat (4) @(negedge clk);
        arstN = 1'b1;
        cycles = 0;
        drainLeft = DRAIN_CYCLES;
        while (drainLeft > 0 && cycles < TEST_CYCLES) begin
            answerFetch();
            @(negedge clk);
            cycles++;
            if (wbValid) begin
                gotReg.push_back(wbReg);
                gotData.push_back(wbData);
            end
            if (instrAddr >= END_ADDR) begin
                drainLeft--;
            end
        end
        if (cycles >= TEST_CYCLES) begin
            $display("test %0d: fetch never got past the end of the program", testNum);
            errors++;
        end
        if (gotReg.size() != expReg.size()) begin
            $display("test %0d: %0d writebacks expected but %0d seen, some are missing or extra",
                     testNum, expReg.size(), gotReg.size());
            errors++;
        end
        n = (gotReg.size() < expReg.size()) ? gotReg.size() : expReg.size();
        errorsList = errors;
        for (int k = 0; k < n && errors == errorsList; k++) begin    // first wrong entry only
            compare($sformatf("test %0d writeback %0d reg", testNum, k),
                    {27'd0, expReg[k]}, {27'd0, gotReg[k]});
            compare($sformatf("test %0d writeback %0d data", testNum, k), expData[k], gotData[k]);
        end
        if (errors != errorsBefore) begin
            failedTests++;
        end
        $display("test %0d: %0d writebacks in %0d cycles, %s", testNum, gotReg.size(), cycles,
                 (errors == errorsBefore) ? "ok" : "mismatch");
    endtask

    initial begin
        arstN = 1'b0;
        instrOk = 1'b0;
        instrData = '0;
        for (int t = 1; t <= NUM_TESTS; t++) begin
            runTest(t);
        end
        $display("%0d of %0d tests passed, %0d errors", NUM_TESTS - failedTests, NUM_TESTS,
                 errors);
        if (errors == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("watchdog: the run took too long and was stopped");
        $display("Testbench failed");
        $finish;
    end

endmodule

// ==== project.f ====
cpuPkg.sv
pipeIntf.sv
fetchStage.sv
decodeStage.sv
executeStage.sv
memoryStage.sv
hazard.sv
cpuTop.sv
tbCpu.sv

// ==== Makefile ====
.PHONY: help test clean

help:
	@echo "make test   build with Verilator and run the testbench"
	@echo "make clean  remove the build directory"
	@echo "make help   show this list"

test:
	verilator --binary --timing --top-module tbCpu -f project.f
	@out=$$(./obj_dir/VtbCpu); echo "$$out"; echo "$$out" | grep -q "Testbench passed"

clean:
	rm -rf obj_dir
